//--- noc_pkg.sv
package noc_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Router geometry and sizes
  ////////////////////////////////////////////////////////////////////////////

  // Five ports, one per mesh direction plus the local tile
  localparam int num_ports = 5;

  // Port indices, also the bit positions of a direction
  localparam int port_north = 0;
  localparam int port_south = 1;
  localparam int port_west  = 2;
  localparam int port_east  = 3;
  localparam int port_local = 4;

  // Flit payload, then the two preamble bits on top
  localparam int data_width = 32;
  localparam int flit_width = data_width + 2;

  // Input queue entries
  localparam int queue_depth = 4;

  ////////////////////////////////////////////////////////////////////////////
  // Flit layout
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [2:0] coord_t;

  typedef struct packed {
    coord_t x;
    coord_t y;
  } xy_t;

  typedef struct packed {
    logic head;
    logic tail;
  } preamble_t;

  typedef logic [4:0] message_t;

  // One-hot output direction, zero means no request
  typedef logic [num_ports-1:0] direction_t;

  localparam direction_t go_north = direction_t'(1 << port_north);
  localparam direction_t go_south = direction_t'(1 << port_south);
  localparam direction_t go_west  = direction_t'(1 << port_west);
  localparam direction_t go_east  = direction_t'(1 << port_east);
  localparam direction_t go_local = direction_t'(1 << port_local);

  // Head flit view, routing field sits in the low bits
  typedef struct packed {
    preamble_t  preamble;
    xy_t        source;
    xy_t        destination;
    message_t   message;
    logic [9:0] reserved;
    direction_t routing;
  } header_t;

  typedef logic [flit_width-1:0] flit_t;

  // Link word, void bit high when no flit is present
  typedef struct packed {
    logic  void_bit;
    flit_t flit;
  } link_t;

  // Queue bookkeeping
  typedef logic [1:0] queue_ptr_t;
  typedef logic [2:0] queue_count_t;

  // Output forwarding FSM
  typedef enum logic {
    fwd_head    = 1'b0,
    fwd_payload = 1'b1
  } fwd_state_t;

endpackage

//--- router_input_queue.sv
`timescale 1ns/1ps

module router_input_queue import noc_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  wr_i,
  input  flit_t data_i,
  input  logic  rd_i,
  output flit_t data_o,
  output logic  empty_o,
  output logic  full_o
);

  // Circular buffer storage
  flit_t        mem [queue_depth];
  queue_ptr_t   wr_ptr;
  queue_ptr_t   rd_ptr;
  queue_count_t count;

  logic bypass;
  logic push;
  logic pop;

  assign empty_o = (count == '0);
  assign full_o  = (count == queue_count_t'(queue_depth));

  // Flit written to an empty queue and read at once never gets stored
  assign bypass = empty_o & wr_i & rd_i;
  assign push   = wr_i & ~full_o & ~bypass;
  assign pop    = rd_i & ~empty_o;

  // Incoming flit shows through while nothing is held
  assign data_o = empty_o ? data_i : mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Pointers wrap on their own, depth is a power of two
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= data_i;
    end
  end

  a_count_in_range: assert property (@(posedge clk) disable iff (rst)
    count <= queue_count_t'(queue_depth))
    else $error("input queue occupancy above depth");

endmodule

//--- xy_lookahead_route.sv
`timescale 1ns/1ps

module xy_lookahead_route import noc_pkg::*; (
  input  xy_t        position_i,
  input  xy_t        destination_i,
  input  direction_t route_i,
  output direction_t next_route_o
);

  // Router the flit reaches after this hop
  xy_t neighbor;

  always_comb begin
    neighbor = position_i;
    case (route_i)
      go_north: neighbor.y = position_i.y - 1'b1;
      go_south: neighbor.y = position_i.y + 1'b1;
      go_west:  neighbor.x = position_i.x - 1'b1;
      go_east:  neighbor.x = position_i.x + 1'b1;
      default:  neighbor = position_i;
    endcase
  end

  // XY order from the neighbor, X first
  always_comb begin
    if (route_i == go_local) begin
      next_route_o = go_local;
    end else if (destination_i.x > neighbor.x) begin
      next_route_o = go_east;
    end else if (destination_i.x < neighbor.x) begin
      next_route_o = go_west;
    end else if (destination_i.y > neighbor.y) begin
      next_route_o = go_south;
    end else if (destination_i.y < neighbor.y) begin
      next_route_o = go_north;
    end else begin
      next_route_o = go_local;
    end
  end

endmodule

//--- router_input_port.sv
`timescale 1ns/1ps

module router_input_port import noc_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  xy_t        position_i,
  input  link_t      link_i,
  input  logic       pop_i,
  output flit_t      head_o,
  output logic       valid_o,
  output direction_t request_o,
  output direction_t next_route_o,
  output logic       stop_o
);

  logic       empty;
  logic       full;
  logic       valid_head;
  logic       valid_tail;
  header_t    head_hdr;
  direction_t saved_request;

  // Every non-void flit goes to the queue, refused while full
  router_input_queue u_router_input_queue (
    .clk     (clk),
    .rst     (rst),
    .wr_i    (~link_i.void_bit),
    .data_i  (link_i.flit),
    .rd_i    (pop_i),
    .data_o  (head_o),
    .empty_o (empty),
    .full_o  (full)
  );

  // Head is valid if stored or passing through on the link
  assign valid_o    = ~(empty & link_i.void_bit);
  assign head_hdr   = header_t'(head_o);
  assign valid_head = valid_o & head_hdr.preamble.head;
  assign valid_tail = valid_o & head_hdr.preamble.tail;

  // Keep the worm's direction while its body drains
  always_ff @(posedge clk) begin
    if (rst) begin
      saved_request <= '0;
    end else if (valid_tail) begin
      saved_request <= '0;
    end else if (valid_head) begin
      saved_request <= head_hdr.routing;
    end
  end

  assign request_o = valid_head ? head_hdr.routing : saved_request;

  // Look-ahead for the router after this one
  xy_lookahead_route u_xy_lookahead_route (
    .position_i    (position_i),
    .destination_i (head_hdr.destination),
    .route_i       (head_hdr.routing),
    .next_route_o  (next_route_o)
  );

  // ACK/NACK back-pressure
  assign stop_o = full;

endmodule

//--- router_arbiter.sv
`timescale 1ns/1ps

module router_arbiter import noc_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [num_ports-1:0] request_i,
  input  logic                 fwd_head_i,
  input  logic                 fwd_tail_i,
  output direction_t           grant_o,
  output logic                 grant_valid_o
);

  // Highest priority input
  logic [2:0] ptr_q;
  // Worm in progress and its owner
  logic       locked_q;
  direction_t held_q;
  direction_t rr_grant;
  logic [2:0] grant_idx;

  // First requester at or after the pointer
  always_comb begin : rr_search
    int   idx;
    logic found;
    rr_grant = '0;
    found    = 1'b0;
    for (int k = 0; k < num_ports; k++) begin
      idx = (int'(ptr_q) + k) % num_ports;
      if (!found && request_i[idx]) begin
        rr_grant[idx] = 1'b1;
        found         = 1'b1;
      end
    end
  end

  assign grant_o       = locked_q ? held_q : rr_grant;
  assign grant_valid_o = |grant_o;

  // Index of the current winner
  always_comb begin
    grant_idx = '0;
    for (int k = 0; k < num_ports; k++) begin
      if (grant_o[k]) begin
        grant_idx = 3'(k);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ptr_q    <= '0;
      locked_q <= 1'b0;
      held_q   <= '0;
    end else if (fwd_tail_i) begin
      // Worm done, winner drops to lowest priority
      locked_q <= 1'b0;
      ptr_q    <= (grant_idx == 3'(num_ports - 1)) ? 3'd0 : grant_idx + 1'b1;
    end else if (fwd_head_i) begin
      locked_q <= 1'b1;
      held_q   <= grant_o;
    end
  end

  a_grant_onehot: assert property (@(posedge clk) disable iff (rst)
    $onehot0(grant_o))
    else $error("arbiter grant not one-hot");

endmodule

//--- router_output_port.sv
`timescale 1ns/1ps

module router_output_port import noc_pkg::*; #(
  parameter int out_port = 0
) (
  input  logic                       clk,
  input  logic                       rst,
  input  flit_t      [num_ports-1:0] heads_i,
  input  logic       [num_ports-1:0] valid_i,
  input  direction_t [num_ports-1:0] requests_i,
  input  direction_t [num_ports-1:0] next_routes_i,
  input  logic                       stop_i,
  output logic       [num_ports-1:0] pop_o,
  output link_t                      link_o
);

  logic [num_ports-1:0] req_vec;
  direction_t           grant;
  logic                 grant_valid;

  fwd_state_t state_q;
  fwd_state_t state_d;
  direction_t sel;
  direction_t sel_q;

  flit_t      xbar_flit;
  logic       xbar_valid;
  direction_t xbar_next;
  header_t    xbar_hdr;
  header_t    out_hdr;
  logic       fwd;
  logic       fwd_is_head;
  logic       fwd_is_tail;

  logic  void_q;
  flit_t flit_q;

  ////////////////////////////////////////////////////////////////////////////
  // Arbitration
  ////////////////////////////////////////////////////////////////////////////

  // Requests for this output, own input excluded (no U-turn)
  always_comb begin
    for (int k = 0; k < num_ports; k++) begin
      req_vec[k] = (k != out_port) ? requests_i[k][out_port] : 1'b0;
    end
  end

  router_arbiter u_router_arbiter (
    .clk           (clk),
    .rst           (rst),
    .request_i     (req_vec),
    .fwd_head_i    (fwd_is_head),
    .fwd_tail_i    (fwd_is_tail),
    .grant_o       (grant),
    .grant_valid_o (grant_valid)
  );

  // New worm only when downstream can take it
  assign sel = (state_q == fwd_payload) ? sel_q :
               ((grant_valid & ~stop_i) ? grant : '0);

  ////////////////////////////////////////////////////////////////////////////
  // Crossbar and look-ahead insertion
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin : crossbar
    xbar_flit  = '0;
    xbar_valid = 1'b0;
    xbar_next  = '0;
    for (int k = 0; k < num_ports; k++) begin
      if (sel[k]) begin
        xbar_flit  = heads_i[k];
        xbar_valid = valid_i[k];
        xbar_next  = next_routes_i[k];
      end
    end
  end

  assign xbar_hdr    = header_t'(xbar_flit);
  assign fwd         = xbar_valid & ~stop_i;
  assign fwd_is_head = fwd & xbar_hdr.preamble.head;
  assign fwd_is_tail = fwd & xbar_hdr.preamble.tail;
  assign pop_o       = sel & {num_ports{fwd}};

  // Head leaves with the direction for the next router
  always_comb begin
    out_hdr = xbar_hdr;
    if (xbar_hdr.preamble.head) begin
      out_hdr.routing = xbar_next;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Forwarding FSM and output register
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      fwd_head:    if (fwd_is_head && !fwd_is_tail) state_d = fwd_payload;
      fwd_payload: if (fwd_is_tail) state_d = fwd_head;
      default:     state_d = fwd_head;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= fwd_head;
      sel_q   <= '0;
      void_q  <= 1'b1;
    end else begin
      state_q <= state_d;
      if (state_q == fwd_head && fwd_is_head) begin
        sel_q <= sel;
      end
      // Output held while stopped
      if (!stop_i) begin
        void_q <= ~fwd;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fwd) begin
      flit_q <= flit_t'(out_hdr);
    end
  end

  assign link_o.void_bit = void_q;
  assign link_o.flit     = flit_q;

  a_expect_head: assert property (@(posedge clk) disable iff (rst)
    (state_q == fwd_head && fwd) |-> xbar_hdr.preamble.head)
    else $error("non-head flit forwarded to idle output %0d", out_port);

  a_sel_onehot: assert property (@(posedge clk) disable iff (rst)
    $onehot0(sel))
    else $error("crossbar selection not one-hot at output %0d", out_port);

  a_no_u_turn: assert property (@(posedge clk) disable iff (rst)
    !requests_i[out_port][out_port])
    else $error("input %0d requests its own port", out_port);

endmodule

//--- lookahead_router.sv
`timescale 1ns/1ps

module lookahead_router import noc_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  xy_t                   position_i,
  input  link_t [num_ports-1:0] link_i,
  output logic  [num_ports-1:0] stop_o,
  output link_t [num_ports-1:0] link_o,
  input  logic  [num_ports-1:0] stop_i
);

  // Per input, shared by all outputs
  flit_t      [num_ports-1:0] heads;
  logic       [num_ports-1:0] valids;
  direction_t [num_ports-1:0] requests;
  direction_t [num_ports-1:0] next_routes;

  // pops[out][in] from each output, OR-ed per input
  logic [num_ports-1:0][num_ports-1:0] pops;
  logic [num_ports-1:0]                pop_in;

  always_comb begin
    pop_in = '0;
    for (int o = 0; o < num_ports; o++) begin
      pop_in = pop_in | pops[o];
    end
  end

  for (genvar i = 0; i < num_ports; i++) begin : g_input
    router_input_port u_router_input_port (
      .clk          (clk),
      .rst          (rst),
      .position_i   (position_i),
      .link_i       (link_i[i]),
      .pop_i        (pop_in[i]),
      .head_o       (heads[i]),
      .valid_o      (valids[i]),
      .request_o    (requests[i]),
      .next_route_o (next_routes[i]),
      .stop_o       (stop_o[i])
    );
  end

  for (genvar o = 0; o < num_ports; o++) begin : g_output
    router_output_port #(
      .out_port (o)
    ) u_router_output_port (
      .clk           (clk),
      .rst           (rst),
      .heads_i       (heads),
      .valid_i       (valids),
      .requests_i    (requests),
      .next_routes_i (next_routes),
      .stop_i        (stop_i[o]),
      .pop_o         (pops[o]),
      .link_o        (link_o[o])
    );
  end

  // Each input feeds at most one output per cycle
  for (genvar i = 0; i < num_ports; i++) begin : g_pop_check
    a_single_reader: assert property (@(posedge clk) disable iff (rst)
      $onehot0({pops[4][i], pops[3][i], pops[2][i], pops[1][i], pops[0][i]}))
      else $error("input %0d popped by more than one output", i);
  end

endmodule

//--- tb_lookahead_router.sv
`timescale 1ns/1ps

module tb_lookahead_router import noc_pkg::*; ();

  // Directed, random, contention and back-pressure phases
  localparam int  num_phases = 4;
  localparam xy_t router_pos = '{x: 3'd3, y: 3'd3};

  logic                  clk = 1'b0;
  logic                  rst = 1'b1;
  xy_t                   position_i;
  link_t [num_ports-1:0] link_i;
  logic  [num_ports-1:0] stop_o;
  link_t [num_ports-1:0] link_o;
  logic  [num_ports-1:0] stop_i;
  logic  [num_ports-1:0] out_void;

  // Flits to send per phase and source, flits expected per output and source
  flit_t gen_q [num_phases*num_ports][$];
  flit_t exp_q [num_ports*num_ports][$];
  int    cum_end [num_phases];
  int    seq_cnt [num_ports];
  int    total_flits = 0;
  int    rx_total    = 0;
  int    phase       = 0;
  logic  gen_done    = 1'b0;
  logic [15:0] lfsr_q = 16'd37;

  // Last transfer seen on each output
  logic  [num_ports-1:0] rx_fire;
  logic  [num_ports-1:0] rx_ok;
  logic  [num_ports-1:0] rx_worm_ok;
  flit_t [num_ports-1:0] rx_flit;
  flit_t [num_ports-1:0] rx_exp;
  logic  [num_ports-1:0] in_worm;
  int                    worm_src [num_ports];

  int data_errors    = 0;
  int worm_errors    = 0;
  int hold_errors    = 0;
  int latency_errors = 0;
  int reset_errors   = 0;
  int lost_errors    = 0;

  lookahead_router u_lookahead_router (
    .clk        (clk),
    .rst        (rst),
    .position_i (position_i),
    .link_i     (link_i),
    .stop_o     (stop_o),
    .link_o     (link_o),
    .stop_i     (stop_i)
  );

  always #20 clk = ~clk;

  always_comb begin
    for (int p = 0; p < num_ports; p++) begin
      out_void[p] = link_o[p].void_bit;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model helpers
  ////////////////////////////////////////////////////////////////////////////

  // 16-bit Galois LFSR, one step per bit drawn
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 16'hB400;
    end
    return n;
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i]   = lfsr_q[0];
      lfsr_q = lfsr_next(lfsr_q);
    end
    return v;
  endfunction

  // Dimension order, X before Y
  function automatic direction_t xy_dir(input xy_t here, input xy_t dst);
    if (dst.x > here.x) return go_east;
    if (dst.x < here.x) return go_west;
    if (dst.y > here.y) return go_south;
    if (dst.y < here.y) return go_north;
    return go_local;
  endfunction

  // Mesh neighbor in a given direction, north is y minus 1
  function automatic xy_t step_to(input xy_t here, input direction_t dir);
    xy_t n;
    n = here;
    if (dir == go_north) n.y = here.y - 3'd1;
    if (dir == go_south) n.y = here.y + 3'd1;
    if (dir == go_west)  n.x = here.x - 3'd1;
    if (dir == go_east)  n.x = here.x + 3'd1;
    return n;
  endfunction

  function automatic int port_of(input direction_t dir);
    int idx;
    idx = 0;
    for (int k = 0; k < num_ports; k++) begin
      if (dir[k]) idx = k;
    end
    return idx;
  endfunction

  // Random destination that does not turn back through the source port
  task automatic pick_dest(input int src, output xy_t dst);
    direction_t route;
    route = '1;
    while (route[src]) begin
      dst.x = coord_t'(take_bits(3));
      dst.y = coord_t'(take_bits(3));
      route = xy_dir(router_pos, dst);
    end
  endtask

  // Source port and sequence number sit in bits 14:12 and 11:5 of every flit
  task automatic make_packet(input int ph, input int src, input xy_t dst, input int len);
    header_t    hdr;
    flit_t      f;
    flit_t      e;
    direction_t route;
    int         out;
    route = xy_dir(router_pos, dst);
    out   = port_of(route);
    for (int i = 0; i < len; i++) begin
      if (i == 0) begin
        hdr.preamble.head = 1'b1;
        hdr.preamble.tail = (len == 1);
        hdr.source        = xy_t'(6'(take_bits(6)));
        hdr.destination   = dst;
        hdr.message       = message_t'(take_bits(5));
        hdr.reserved      = {3'(src), 7'(seq_cnt[src])};
        hdr.routing       = route;
        f = flit_t'(hdr);
        // Head leaves with the direction the next router takes
        e      = f;
        e[4:0] = xy_dir(step_to(router_pos, route), dst);
      end else begin
        f        = {1'b0, (i == len - 1), take_bits(32)};
        f[14:12] = 3'(src);
        f[11:5]  = 7'(seq_cnt[src]);
        e        = f;
      end
      seq_cnt[src]++;
      gen_q[ph*num_ports+src].push_back(f);
      exp_q[out*num_ports+src].push_back(e);
      total_flits++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Link drivers, 2 ns after the rising edge
  ////////////////////////////////////////////////////////////////////////////

  initial begin : drive_inputs
    int idx;
    rst        = 1'b1;
    position_i = router_pos;
    stop_i     = '0;
    for (int s = 0; s < num_ports; s++) begin
      link_i[s] = '{void_bit: 1'b1, flit: '0};
    end
    repeat (8) @(posedge clk);
    #2;
    rst = 1'b0;
    forever begin
      for (int s = 0; s < num_ports; s++) begin
        idx = phase * num_ports + s;
        if (gen_q[idx].size() > 0) begin
          link_i[s] = '{void_bit: 1'b0, flit: gen_q[idx][0]};
        end else begin
          link_i[s] = '{void_bit: 1'b1, flit: '0};
        end
      end
      // Last phase stalls each output three cycles in four
      for (int p = 0; p < num_ports; p++) begin
        stop_i[p] = (phase == num_phases - 1) ? |take_bits(2) : 1'b0;
      end
      // Flit taken at the next edge unless the router says stop
      @(negedge clk);
      for (int s = 0; s < num_ports; s++) begin
        idx = phase * num_ports + s;
        if (!link_i[s].void_bit && !stop_o[s]) begin
          void'(gen_q[idx].pop_front());
        end
      end
      @(posedge clk);
      #2;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output monitor, scoreboard lookup and worm tracking
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin : check_outputs
    int    src;
    flit_t f;
    for (int p = 0; p < num_ports; p++) begin
      rx_fire[p]    = 1'b0;
      rx_ok[p]      = 1'b0;
      rx_worm_ok[p] = 1'b1;
      if (rst) begin
        in_worm[p] = 1'b0;
      end else if (!out_void[p] && !stop_i[p]) begin
        f             = link_o[p].flit;
        src           = int'(f[14:12]);
        rx_fire[p]    = 1'b1;
        rx_flit[p]    = f;
        rx_exp[p]     = '0;
        rx_total++;
        if (src < num_ports && exp_q[p*num_ports+src].size() > 0) begin
          rx_exp[p] = exp_q[p*num_ports+src].pop_front();
          rx_ok[p]  = (f === rx_exp[p]);
        end
        // Between head and tail only one source may use the output
        if (!in_worm[p]) begin
          rx_worm_ok[p] = f[33];
          if (f[33] && !f[32]) begin
            in_worm[p]  = 1'b1;
            worm_src[p] = src;
          end
        end else begin
          rx_worm_ok[p] = !f[33] && (src == worm_src[p]);
          if (f[32]) in_worm[p] = 1'b0;
        end
      end
    end
  end

  for (genvar p = 0; p < num_ports; p++) begin : g_out_check
    a_data_match: assert property (@(posedge clk) disable iff (rst)
      rx_fire[p] |-> rx_ok[p])
      else begin
        data_errors++;
        $display("[ERROR] time %0d ns: output %0d received %h, expected %h",
                 $time, p, rx_flit[p], rx_exp[p]);
      end

    a_worm_intact: assert property (@(posedge clk) disable iff (rst)
      rx_fire[p] |-> rx_worm_ok[p])
      else begin
        worm_errors++;
        $display("[ERROR] time %0d ns: output %0d broke a worm with flit %h",
                 $time, p, rx_flit[p]);
      end

    // Stopped output keeps its void bit, and its flit when one is shown
    a_hold_on_stop: assert property (@(posedge clk) disable iff (rst)
      stop_i[p] |=> ($stable(out_void[p]) && (out_void[p] || $stable(link_o[p].flit))))
      else begin
        hold_errors++;
        $display("[ERROR] time %0d ns: output %0d changed while stop_i was high", $time, p);
      end
  end

  a_single_cycle: assert property (@(posedge clk) disable iff (rst)
    (phase == 0 && !link_i[port_west].void_bit) |=> !link_o[port_east].void_bit)
    else begin
      latency_errors++;
      $display("[ERROR] time %0d ns: west flit not on east output one cycle later", $time);
    end

  a_reset_state: assert property (@(posedge clk)
    $fell(rst) |-> (&out_void && stop_o == '0))
    else begin
      reset_errors++;
      $display("[ERROR] time %0d ns: router not idle after reset", $time);
    end

  ////////////////////////////////////////////////////////////////////////////
  // Phase control, watchdog and summary
  ////////////////////////////////////////////////////////////////////////////

  initial begin : run_phases
    xy_t dst;
    int  left;
    int  errs;
    // Single flit, west to an idle east output
    make_packet(0, port_west, '{x: 3'd5, y: 3'd3}, 1);
    cum_end[0] = total_flits;
    for (int i = 0; i < 6; i++) begin
      for (int s = 0; s < num_ports; s++) begin
        pick_dest(s, dst);
        make_packet(1, s, dst, 1 + int'(take_bits(2)));
      end
    end
    cum_end[1] = total_flits;
    // Four mesh inputs fight for the local output
    for (int i = 0; i < 4; i++) begin
      for (int s = 0; s < port_local; s++) begin
        make_packet(2, s, router_pos, 3 + int'(take_bits(2)));
      end
    end
    cum_end[2] = total_flits;
    for (int i = 0; i < 6; i++) begin
      for (int s = 0; s < num_ports; s++) begin
        pick_dest(s, dst);
        make_packet(3, s, dst, 1 + int'(take_bits(2)));
      end
    end
    cum_end[3] = total_flits;
    gen_done = 1'b1;

    wait (rst == 1'b0);
    for (int ph = 0; ph < num_phases; ph++) begin
      @(posedge clk);
      phase = ph;
      while (rx_total < cum_end[ph]) begin
        @(posedge clk);
      end
      repeat (4) @(posedge clk);
    end

    left = 0;
    for (int k = 0; k < num_ports * num_ports; k++) begin
      left += exp_q[k].size();
    end
    a_all_delivered: assert (left == 0)
      else begin
        lost_errors++;
        $display("[ERROR] time %0d ns: %0d expected flits never delivered", $time, left);
      end

    errs = data_errors + worm_errors + hold_errors + latency_errors + reset_errors +
           lost_errors;
    $display("errors: data %0d, worm %0d, hold %0d, latency %0d, reset %0d, lost %0d",
             data_errors, worm_errors, hold_errors, latency_errors, reset_errors,
             lost_errors);
    if (errs == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // Twenty clock periods per flit sent
  initial begin : watchdog
    wait (gen_done);
    #(40 * total_flits * 20);
    $display("Timeout: only %0d of %0d flits came out of the router", rx_total, total_flits);
    $display("TEST FAIL");
    $finish;
  end

endmodule

//--- sources.f
noc_pkg.sv
router_input_queue.sv
xy_lookahead_route.sv
router_input_port.sv
router_arbiter.sv
router_output_port.sv
lookahead_router.sv
tb_lookahead_router.sv
